/* femtoCore.f */
+incdir+hw
hw/rv_pkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/shiftCounter.sv
hw/alu.sv
hw/controlFsm.sv
hw/femtoCore.sv
test/femtoCore_sva.sv
test/femtoCore_tb.sv

/* hw/alu.sv */
`timescale 1ns/10ps

`include "rv_consts.svh"

module alu import rv_pkg::*; (
   input  logic          clk,
   input  logic          mem_rstrb,
   input  decodedInstr_t dec,
   input  logic [31:0]   rs1,
   input  logic [31:0]   rs2,
   input  logic          startAlu,
   output logic [31:0]   aluOut,
   output logic [31:0]   aluSum,
   output logic          branchTaken,
   output logic          shiftBusy
);

   logic [31:0] aluIn2;
   logic [32:0] aluMinus;
   logic        lt;
   logic        ltu;
   logic        eq;
   logic [31:0] shiftResult;

   // Register operand for OP and BRANCH, I-immediate for the rest
   assign aluIn2 = (dec.op == OP || dec.op == BRANCH) ? rs2 : dec.immI;
   assign aluSum = rs1 + aluIn2;  // Also the JALR target

   // One 33-bit subtract gives difference, borrow and equality
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign ltu      = aluMinus[32];
   assign lt       = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[32];  // Signs differ
   assign eq       = (aluMinus[31:0] == 32'd0);

   always_comb begin
      case (dec.funct3)
         3'b000:  aluOut = (dec.altFunct & dec.regOperand) ? aluMinus[31:0] : aluSum;
         3'b010:  aluOut = {31'd0, lt};   // SLT
         3'b011:  aluOut = {31'd0, ltu};  // SLTU
         3'b100:  aluOut = rs1 ^ aluIn2;
         3'b110:  aluOut = rs1 | aluIn2;
         3'b111:  aluOut = rs1 & aluIn2;
         default: aluOut = shiftResult;   // SLL, SRL, SRA
      endcase
   end

   // Branch condition from funct3, only meaningful for BRANCH
   always_comb begin
      case (dec.funct3)
         3'b000:  branchTaken = eq;    // BEQ
         3'b001:  branchTaken = !eq;   // BNE
         3'b100:  branchTaken = lt;    // BLT
         3'b101:  branchTaken = !lt;   // BGE
         3'b110:  branchTaken = ltu;   // BLTU
         3'b111:  branchTaken = !ltu;  // BGEU
         default: branchTaken = 1'b0;
      endcase
   end

   shiftCounter u_shiftCounter (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .start     (startAlu),
      .operand   (rs1),
      .amount    (aluIn2[`SHAMT_WIDTH-1:0]),
      .funct3    (dec.funct3),
      .arith     (dec.altFunct),
      .result    (shiftResult),
      .busy      (shiftBusy)
   );

endmodule

/* hw/controlFsm.sv */
`timescale 1ns/10ps

`include "rv_consts.svh"

module controlFsm import rv_pkg::*; (
   input  logic          clk,
   input  logic          mem_rstrb,
   input  decodedInstr_t dec,
   input  logic [31:0]   rs1,
   input  logic [31:0]   rs2,
   input  logic [31:0]   aluOut,
   input  logic [31:0]   aluSum,
   input  logic          branchTaken,
   input  logic          shiftBusy,
   input  logic [31:0]   memRdata,
   input  logic          memBusy,
   output logic          loadInstr,
   output logic          startAlu,
   output logic          regWrite,
   output logic [31:0]   wbData,
   output memReq_t       memReq
);

   localparam int PadWidth = 32 - `ADDR_WIDTH;

   state_e                 state;
   logic [`ADDR_WIDTH-1:0] pc;
   logic [`ADDR_WIDTH-1:0] pcPlus4;
   logic [`ADDR_WIDTH-1:0] pcPlusImm;
   logic [`ADDR_WIDTH-1:0] lsAddr;
   logic [31:0]            pcImm;
   logic [31:0]            lsImm;
   logic                   isAluOp;
   logic                   needWait;
   logic                   waitDone;
   logic                   writesRd;

   // One PC adder shared by JAL, branches and AUIPC
   assign pcImm     = (dec.op == JAL) ? dec.immJ : (dec.op == AUIPC) ? dec.immU : dec.immB;
   assign pcPlusImm = pc + pcImm[`ADDR_WIDTH-1:0];
   assign pcPlus4   = pc + `ADDR_WIDTH'(4);

   assign lsImm  = (dec.op == STORE) ? dec.immS : dec.immI;
   assign lsAddr = rs1[`ADDR_WIDTH-1:0] + lsImm[`ADDR_WIDTH-1:0];

   assign isAluOp  = (dec.op == OP) || (dec.op == OPIMM);
   assign needWait = (dec.op == LOAD) || (dec.op == STORE) ||
                     (isAluOp && dec.funct3[1:0] == 2'b01);  // Shifts wait on the counter
   assign waitDone = !memBusy && !shiftBusy;
   assign writesRd = !(dec.op inside {STORE, BRANCH, ILLEGAL});

   assign loadInstr = (state == WAIT_INSTR) && !memBusy;
   assign startAlu  = (state == EXECUTE) && isAluOp;
   // Single write per instruction, after any wait
   assign regWrite  = writesRd && (((state == EXECUTE) && !needWait) ||
                                   ((state == WAIT_ALU_MEM) && waitDone));

   always_comb begin
      case (dec.op)
         LUI:       wbData = dec.immU;
         AUIPC:     wbData = {{PadWidth{1'b0}}, pcPlusImm};
         JAL, JALR: wbData = {{PadWidth{1'b0}}, pcPlus4};  // Link address
         LOAD:      wbData = memRdata;
         default:   wbData = aluOut;
      endcase
   end

   // Instruction address while fetching, data address otherwise
   assign memReq.addr  = (state == FETCH || state == WAIT_INSTR) ?
                         {{PadWidth{1'b0}}, pc} : {{PadWidth{1'b0}}, lsAddr};
   assign memReq.wdata = rs2;
   assign memReq.read  = (state == FETCH) || ((state == EXECUTE) && dec.op == LOAD);
   assign memReq.write = (state == EXECUTE) && (dec.op == STORE);

   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         state <= WAIT_ALU_MEM;  // Let a busy memory settle first
         pc    <= `ADDR_WIDTH'(`RESET_ADDR);
      end else begin
         case (state)
            FETCH: state <= WAIT_INSTR;
            WAIT_INSTR: begin
               if (!memBusy) state <= EXECUTE;
            end
            EXECUTE: begin
               if (dec.op == JALR) begin
                  pc <= {aluSum[`ADDR_WIDTH-1:1], 1'b0};  // Bit 0 cleared
               end else if (dec.op == JAL || (dec.op == BRANCH && branchTaken)) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               state <= needWait ? WAIT_ALU_MEM : FETCH;
            end
            WAIT_ALU_MEM: begin
               if (waitDone) state <= FETCH;
            end
            default: state <= WAIT_ALU_MEM;
         endcase
      end
   end

endmodule

/* hw/femtoCore.sv */
`timescale 1ns/10ps

module femtoCore import rv_pkg::*; (
   input  logic        clk,
   input  logic        mem_rstrb,  // Synchronous core reset
   output memReq_t     memReq,
   input  logic [31:0] memRdata,   // Instructions and load data
   input  logic        memBusy
);

   decodedInstr_t dec;
   logic [31:0]   rs1;
   logic [31:0]   rs2;
   logic [31:0]   aluOut;
   logic [31:0]   aluSum;
   logic [31:0]   wbData;
   logic          branchTaken;
   logic          shiftBusy;
   logic          loadInstr;
   logic          startAlu;
   logic          regWrite;

   instrDecoder u_instrDecoder (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .loadInstr (loadInstr),
      .memRdata  (memRdata),
      .dec       (dec)
   );

   // Operand read shares the fetch cycle with the decoder
   regFile u_regFile (
      .clk       (clk),
      .loadInstr (loadInstr),
      .memRdata  (memRdata),
      .dec       (dec),
      .regWrite  (regWrite),
      .wbData    (wbData),
      .rs1       (rs1),
      .rs2       (rs2)
   );

   alu u_alu (
      .clk         (clk),
      .mem_rstrb   (mem_rstrb),
      .dec         (dec),
      .rs1         (rs1),
      .rs2         (rs2),
      .startAlu    (startAlu),
      .aluOut      (aluOut),
      .aluSum      (aluSum),
      .branchTaken (branchTaken),
      .shiftBusy   (shiftBusy)
   );

   controlFsm u_controlFsm (
      .clk         (clk),
      .mem_rstrb   (mem_rstrb),
      .dec         (dec),
      .rs1         (rs1),
      .rs2         (rs2),
      .aluOut      (aluOut),
      .aluSum      (aluSum),
      .branchTaken (branchTaken),
      .shiftBusy   (shiftBusy),
      .memRdata    (memRdata),
      .memBusy     (memBusy),
      .loadInstr   (loadInstr),
      .startAlu    (startAlu),
      .regWrite    (regWrite),
      .wbData      (wbData),
      .memReq      (memReq)
   );

endmodule

/* hw/instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder import rv_pkg::*; (
   input  logic          clk,
   input  logic          mem_rstrb,
   input  logic          loadInstr,  // Fetched word present on memRdata
   input  logic [31:0]   memRdata,
   output decodedInstr_t dec
);

   // Bits 1:0 are always 11 in RV32I and are not kept
   logic [31:2] instr;

   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         instr <= '1;  // Opcode field of ones decodes as ILLEGAL
      end else if (loadInstr) begin
         instr <= memRdata[31:2];
      end
   end

   always_comb begin
      case (instr[6:2])
         LOAD, OPIMM, AUIPC, STORE, OP, LUI, BRANCH, JALR, JAL: begin
            dec.op = opcode_e'(instr[6:2]);
         end
         default: begin
            dec.op = ILLEGAL;  // Unknown class, nothing is written
         end
      endcase

      dec.rd         = instr[11:7];
      dec.funct3     = instr[14:12];
      dec.altFunct   = instr[30];
      dec.regOperand = instr[5];  // Tells ADD from ADDI when bit 30 is set

      // Sign-extended immediates, bit 31 is the sign in all formats
      dec.immI = {{21{instr[31]}}, instr[30:20]};
      dec.immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      dec.immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      dec.immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      dec.immU = {instr[31:12], 12'b0};  // Low bits zero
   end

endmodule

/* hw/regFile.sv */
`timescale 1ns/10ps

`include "rv_consts.svh"

module regFile import rv_pkg::*; (
   input  logic          clk,
   input  logic          loadInstr,
   input  logic [31:0]   memRdata,  // Source fields taken straight from the fetched word
   input  decodedInstr_t dec,
   input  logic          regWrite,
   input  logic [31:0]   wbData,
   output logic [31:0]   rs1,
   output logic [31:0]   rs2
);

   logic [31:0] regs [`NUM_REGS];
   logic [4:0]  rs1Idx;
   logic [4:0]  rs2Idx;

   assign rs1Idx = memRdata[19:15];
   assign rs2Idx = memRdata[24:20];

   always_ff @(posedge clk) begin
      // Operands captured together with the instruction word
      if (loadInstr) begin
         rs1 <= (rs1Idx == 5'd0) ? 32'd0 : regs[rs1Idx];  // x0 reads zero
         rs2 <= (rs2Idx == 5'd0) ? 32'd0 : regs[rs2Idx];
      end
      if (regWrite && dec.rd != 5'd0) begin
         regs[dec.rd] <= wbData;  // Writes to x0 are dropped
      end
   end

endmodule

/* hw/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Width of the PC and of the load/store address adders
// Upper address bits on the bus are tied to zero
`define ADDR_WIDTH 24

// First fetch address after reset
`define RESET_ADDR 0

// Integer register file size, x0 included
`define NUM_REGS 32

// Shift amount field of SLL/SRL/SRA and their immediate forms
`define SHAMT_WIDTH 5

`endif

/* hw/rv_pkg.sv */
package rv_pkg;

   // Instruction class, encoded as instruction bits 6:2
   typedef enum logic [4:0] {
      LOAD    = 5'b00000,  // rd <- mem[rs1 + immI]
      OPIMM   = 5'b00100,  // rd <- rs1 op immI
      AUIPC   = 5'b00101,  // rd <- PC + immU
      STORE   = 5'b01000,  // mem[rs1 + immS] <- rs2
      OP      = 5'b01100,  // rd <- rs1 op rs2
      LUI     = 5'b01101,  // rd <- immU
      BRANCH  = 5'b11000,  // PC <- PC + immB when taken
      JALR    = 5'b11001,  // rd <- PC + 4, PC <- rs1 + immI
      JAL     = 5'b11011,  // rd <- PC + 4, PC <- PC + immJ
      ILLEGAL = 5'b11111   // Anything else, runs as a no-op
   } opcode_e;

   // Sequencer states, one-hot
   typedef enum logic [3:0] {
      FETCH        = 4'b0001,
      WAIT_INSTR   = 4'b0010,
      EXECUTE      = 4'b0100,
      WAIT_ALU_MEM = 4'b1000
   } state_e;

   typedef struct packed {
      opcode_e     op;
      logic [4:0]  rd;
      logic [2:0]  funct3;
      logic        altFunct;    // Bit 30, SUB and SRA
      logic        regOperand;  // Bit 5, register form of OP
      logic [31:0] immI;
      logic [31:0] immS;
      logic [31:0] immB;
      logic [31:0] immJ;
      logic [31:0] immU;
   } decodedInstr_t;

   // Request side of the memory bus
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic        read;   // One-cycle read strobe
      logic        write;  // One-cycle full-word write strobe
   } memReq_t;

endpackage

/* hw/shiftCounter.sv */
`timescale 1ns/10ps

`include "rv_consts.svh"

module shiftCounter (
   input  logic                    clk,
   input  logic                    mem_rstrb,
   input  logic                    start,
   input  logic [31:0]             operand,
   input  logic [`SHAMT_WIDTH-1:0] amount,
   input  logic [2:0]              funct3,
   input  logic                    arith,   // SRA fills with the sign bit
   output logic [31:0]             result,
   output logic                    busy
);

   logic [`SHAMT_WIDTH-1:0] count;  // Shifts still to do
   logic                    isShift;
   logic                    load;

   assign isShift = (funct3[1:0] == 2'b01);  // 001 is SLL, 101 is SRL/SRA
   assign load    = start & isShift;
   assign busy    = load | (count != '0);    // Start cycle counts as busy

   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         count <= '0;
      end else if (load) begin
         count <= amount;
      end else if (count != '0) begin
         count <= count - 1'b1;
      end
   end

   // One bit per cycle
   always_ff @(posedge clk) begin
      if (load) begin
         result <= operand;
      end else if (count != '0) begin
         if (funct3[2]) begin
            result <= {arith & result[31], result[31:1]};  // SRL or SRA
         end else begin
            result <= {result[30:0], 1'b0};
         end
      end
   end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module femtoCore_tb -f femtoCore.f -o simv

status=0
out=$(./obj_dir/simv 2>&1) || status=$?
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
   exit 0
fi
exit 1

/* test/femtoCore_sva.sv */
`timescale 1ns/10ps

module femtoCore_sva import rv_pkg::*; (
   input logic    clk,
   input logic    mem_rstrb,
   input state_e  state,
   input memReq_t memReq,
   input logic    memBusy
);

   // Only one strobe per cycle on the bus
   assert property (@(posedge clk) disable iff (mem_rstrb)
      !(memReq.read && memReq.write))
      else $error("Read and write strobes high in the same cycle");

   // Busy memory blocks any new request
   assert property (@(posedge clk) disable iff (mem_rstrb)
      memBusy |-> !(memReq.read || memReq.write))
      else $error("Request issued while memory busy");

   // Exactly one state bit set
   assert property (@(posedge clk) disable iff (mem_rstrb)
      $onehot(state))
      else $error("FSM state is not one-hot");

endmodule

bind controlFsm femtoCore_sva u_sva (
   .clk       (clk),
   .mem_rstrb (mem_rstrb),
   .state     (state),
   .memReq    (memReq),
   .memBusy   (memBusy)
);

/* test/femtoCore_tb.sv */
`timescale 1ns/10ps

module femtoCore_tb import rv_pkg::*;;

   localparam logic [3:0] KindOp = 4'd0;
   localparam logic [3:0] KindImm = 4'd1;
   localparam logic [3:0] KindBranch = 4'd2;
   localparam logic [3:0] KindJal = 4'd3;
   localparam logic [3:0] KindJalr = 4'd4;
   localparam logic [3:0] KindLui = 4'd5;
   localparam logic [3:0] KindAuipc = 4'd6;
   localparam logic [3:0] KindMem = 4'd7;
   localparam logic [3:0] KindX0 = 4'd8;
   localparam int NumRows = 38;
   localparam int CycleLimit = NumRows * 200;  // 200 cycles per row

   // funct is {bit 30, funct3}; openExp asks for a computed result, randB a random b
   typedef struct packed {
      logic [3:0]  kind;
      logic [3:0]  funct;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] expected;
      logic        openExp;
      logic        randB;
   } row_t;

   row_t testRows [NumRows] = '{
      '{KindOp, 4'h0, 32'h7fffffff, 32'h00000001, 32'h80000000, 1'b0, 1'b0},  // ADD overflow
      '{KindOp, 4'h8, 32'h00000005, 32'h00000007, 32'hfffffffe, 1'b0, 1'b0},  // SUB
      '{KindOp, 4'h4, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h0, 1'b1, 1'b0},
      '{KindOp, 4'h6, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h0, 1'b1, 1'b0},
      '{KindOp, 4'h7, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h0, 1'b1, 1'b0},
      '{KindOp, 4'h2, 32'hfffffff0, 32'h00000003, 32'h00000001, 1'b0, 1'b0},  // SLT
      '{KindOp, 4'h3, 32'hfffffff0, 32'h00000003, 32'h00000000, 1'b0, 1'b0},  // SLTU
      '{KindOp, 4'h1, 32'h8000000f, 32'h00000004, 32'h0, 1'b1, 1'b0},
      '{KindOp, 4'h5, 32'hf0000000, 32'h00000004, 32'h0, 1'b1, 1'b0},
      '{KindOp, 4'hd, 32'h80000f00, 32'h00000007, 32'h0, 1'b1, 1'b0},  // SRA
      '{KindImm, 4'h0, 32'h12345678, 32'hfffff800, 32'h0, 1'b1, 1'b0},
      '{KindImm, 4'h2, 32'hfffffff0, 32'h000007ff, 32'h0, 1'b1, 1'b0},
      '{KindImm, 4'h3, 32'h00000005, 32'hfffffff8, 32'h0, 1'b1, 1'b0},
      '{KindImm, 4'h4, 32'ha5a5a5a5, 32'h000000f0, 32'h0, 1'b1, 1'b0},
      '{KindImm, 4'h6, 32'ha5a5a5a5, 32'h00000f0f, 32'h0, 1'b1, 1'b0},
      '{KindImm, 4'h7, 32'ha5a5a5a5, 32'h0000033c, 32'h0, 1'b1, 1'b0},
      '{KindImm, 4'h1, 32'h87654321, 32'h0, 32'h0, 1'b1, 1'b1},  // Random amounts
      '{KindImm, 4'h5, 32'h87654321, 32'h0, 32'h0, 1'b1, 1'b1},
      '{KindImm, 4'hd, 32'h87654321, 32'h0, 32'h0, 1'b1, 1'b1},
      '{KindBranch, 4'h0, 32'h5, 32'h5, 32'h1, 1'b0, 1'b0},
      '{KindBranch, 4'h0, 32'h5, 32'h6, 32'h2, 1'b0, 1'b0},
      '{KindBranch, 4'h1, 32'h5, 32'h6, 32'h0, 1'b1, 1'b0},
      '{KindBranch, 4'h1, 32'h5, 32'h5, 32'h0, 1'b1, 1'b0},
      '{KindBranch, 4'h4, 32'hfffffffe, 32'h1, 32'h0, 1'b1, 1'b0},
      '{KindBranch, 4'h4, 32'h1, 32'hfffffffe, 32'h0, 1'b1, 1'b0},
      '{KindBranch, 4'h5, 32'h1, 32'hfffffffe, 32'h0, 1'b1, 1'b0},
      '{KindBranch, 4'h5, 32'hfffffffe, 32'h1, 32'h0, 1'b1, 1'b0},
      '{KindBranch, 4'h6, 32'h1, 32'hfffffffe, 32'h0, 1'b1, 1'b0},
      '{KindBranch, 4'h6, 32'hfffffffe, 32'h1, 32'h0, 1'b1, 1'b0},
      '{KindBranch, 4'h7, 32'hfffffffe, 32'h1, 32'h0, 1'b1, 1'b0},
      '{KindBranch, 4'h7, 32'h1, 32'hfffffffe, 32'h0, 1'b1, 1'b0},
      '{KindJal, 4'h0, 32'h0, 32'h0, 32'd24, 1'b0, 1'b0},
      '{KindJalr, 4'h0, 32'd29, 32'd3, 32'd24, 1'b0, 1'b0},
      '{KindJalr, 4'h0, 32'd35, 32'hfffffffe, 32'h0, 1'b1, 1'b0},  // Odd target
      '{KindLui, 4'h0, 32'h0, 32'habcde123, 32'habcde000, 1'b0, 1'b0},
      '{KindAuipc, 4'h0, 32'h0, 32'h00123456, 32'h0, 1'b1, 1'b0},
      '{KindMem, 4'h0, 32'hdeadbeef, 32'h0, 32'h0, 1'b1, 1'b0},
      '{KindX0, 4'h0, 32'h13572468, 32'h0, 32'h0, 1'b0, 1'b0}  // x0 keeps reading zero
   };

   logic        clk;
   logic        mem_rstrb;
   memReq_t     memReq;
   logic [31:0] memRdata;
   logic        memBusy;
   logic [31:0] mem [4096];
   logic [1:0]  busyCnt;
   logic        storeSeen;
   logic [31:0] storeVal;
   integer      seed = 32'h8bbe;
   int          cycles = 0;

   femtoCore u_dut (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .memReq    (memReq),
      .memRdata  (memRdata),
      .memBusy   (memBusy)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   assign memBusy = (busyCnt != 2'd0);

   // Memory model, random 0..3 busy cycles after every request
   always @(posedge clk) begin
      if (mem_rstrb) begin
         busyCnt   <= 2'd0;
         storeSeen <= 1'b0;
      end else if (memReq.read || memReq.write) begin
         // Every access is a whole aligned word
         checkValue({30'd0, memReq.addr[1:0]}, 32'd0, "bus address bits 1:0");
         busyCnt <= 2'($random(seed));
         if (memReq.read) memRdata <= mem[memReq.addr[13:2]];
         if (memReq.write) begin
            mem[memReq.addr[13:2]] <= memReq.wdata;
            if (memReq.addr == 32'h800 && !storeSeen) begin  // Result mailbox
               storeSeen <= 1'b1;
               storeVal  <= memReq.wdata;
            end
         end
      end else if (busyCnt != 2'd0) begin
         busyCnt <= busyCnt - 2'd1;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > CycleLimit) begin
         $display("Timeout: the core stopped storing results");
         $display("SIMULATION FAILED");
         $fatal(1);
      end
   end

   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // RV32I result of the instruction under test, as stored at 0x800
   function automatic logic [31:0] refResult(input row_t r);
      logic [31:0] y;
      logic [31:0] res;
      logic        taken;
      y = r.b;
      if (r.kind == KindImm) begin
         y = (r.funct[1:0] == 2'b01) ? {27'd0, r.b[4:0]} : {{20{r.b[11]}}, r.b[11:0]};
      end
      res = 32'd0;
      case (r.kind)
         KindOp, KindImm: begin
            case (r.funct[2:0])
               3'd0: res = (r.funct[3] && r.kind == KindOp) ? r.a - y : r.a + y;
               3'd1: res = r.a << y[4:0];
               3'd2: res = {31'd0, $signed(r.a) < $signed(y)};
               3'd3: res = {31'd0, r.a < y};
               3'd4: res = r.a ^ y;
               3'd5: begin
                  if (r.funct[3]) res = $signed(r.a) >>> y[4:0];
                  else res = r.a >> y[4:0];
               end
               3'd6: res = r.a | y;
               default: res = r.a & y;
            endcase
         end
         KindBranch: begin
            case (r.funct[2:0])
               3'd0: taken = (r.a == r.b);
               3'd1: taken = (r.a != r.b);
               3'd4: taken = $signed(r.a) < $signed(r.b);
               3'd5: taken = $signed(r.a) >= $signed(r.b);
               3'd6: taken = r.a < r.b;
               default: taken = r.a >= r.b;
            endcase
            res = taken ? 32'd1 : 32'd2;
         end
         KindJal, KindJalr: res = 32'd24;  // Link of the jump at 20
         KindLui: res = {r.b[31:12], 12'd0};
         KindAuipc: res = {r.b[31:12], 12'd0} + 32'd20;
         KindMem: res = r.a;
         default: res = 32'd0;
      endcase
      return res;
   endfunction

   // Operands into x1/x2, x4 = 0x1000, test code at 20, result stored via x4 - 0x800
   task automatic loadProgram(input row_t r);
      logic [31:0] prog [$];
      logic [11:0] shImm;
      prog.push_back({20'((r.a + 32'h800) >> 12), 5'd1, 7'b0110111});
      prog.push_back(encI(r.a[11:0], 5'd1, 3'd0, 5'd1, 7'b0010011));
      prog.push_back({20'((r.b + 32'h800) >> 12), 5'd2, 7'b0110111});
      prog.push_back(encI(r.b[11:0], 5'd2, 3'd0, 5'd2, 7'b0010011));
      prog.push_back({20'd1, 5'd4, 7'b0110111});
      shImm = {r.funct[3] ? 7'b0100000 : 7'd0, r.b[4:0]};
      case (r.kind)
         KindOp: prog.push_back(encR(r.funct[3] ? 7'b0100000 : 7'd0, 5'd2, 5'd1,
                                     r.funct[2:0], 5'd3));
         KindImm: prog.push_back(encI((r.funct[1:0] == 2'b01) ? shImm : r.b[11:0], 5'd1,
                                      r.funct[2:0], 5'd3, 7'b0010011));
         KindBranch: begin
            prog.push_back(encB(13'd12, 5'd2, 5'd1, r.funct[2:0]));
            prog.push_back(encI(12'd2, 5'd0, 3'd0, 5'd3, 7'b0010011));
            prog.push_back(encJ(21'd8, 5'd0));
            prog.push_back(encI(12'd1, 5'd0, 3'd0, 5'd3, 7'b0010011));
         end
         KindJal: begin
            prog.push_back(encJ(21'd8, 5'd3));
            prog.push_back(encI(12'd99, 5'd0, 3'd0, 5'd3, 7'b0010011));  // Skipped
         end
         KindJalr: begin
            prog.push_back(encI(r.b[11:0], 5'd1, 3'd0, 5'd3, 7'b1100111));
            prog.push_back(encI(12'd99, 5'd0, 3'd0, 5'd3, 7'b0010011));
            prog.push_back(encI(12'd98, 5'd0, 3'd0, 5'd3, 7'b0010011));
         end
         KindLui: prog.push_back({r.b[31:12], 5'd3, 7'b0110111});
         KindAuipc: prog.push_back({r.b[31:12], 5'd3, 7'b0010111});
         KindMem: begin
            prog.push_back(encS(12'h400, 5'd1, 5'd0));
            prog.push_back(encI(12'h400, 5'd0, 3'b010, 5'd3, 7'b0000011));  // LW back
         end
         default: begin
            prog.push_back(encI(12'd0, 5'd1, 3'd0, 5'd0, 7'b0010011));  // Write to x0
            prog.push_back(encR(7'd0, 5'd0, 5'd0, 3'b110, 5'd3));
         end
      endcase
      prog.push_back(encS(12'h800, 5'd3, 5'd4));
      prog.push_back(encJ(21'd0, 5'd0));  // Park here
      for (int k = 0; k < 4096; k++) begin
         mem[k] = 32'(k) * 32'h9e3779b1;
      end
      for (int k = 0; k < prog.size(); k++) begin
         mem[k] = prog[k];
      end
   endtask

   task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1);
      end
   endtask

   task automatic runRow(input row_t r, input int row);
      @(posedge clk);
      mem_rstrb <= 1'b1;
      loadProgram(r);
      repeat (3) @(posedge clk);
      mem_rstrb <= 1'b0;
      @(posedge clk);
      while (!storeSeen) @(posedge clk);
      checkValue(storeVal, r.expected, $sformatf("row %0d result", row));
   endtask

   initial begin
      row_t r;
      mem_rstrb = 1'b1;
      busyCnt   = 2'd0;
      memRdata  = 32'd0;
      for (int i = 0; i < NumRows; i++) begin
         r = testRows[i];
         if (r.randB) r.b = 32'($random(seed));
         if (r.openExp) r.expected = refResult(r);
         runRow(r, i);
      end
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule
